//--- run.sh
#!/bin/sh
# Build the DMA controller testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dmacTb -f src.f

out=$(./obj_dir/VdmacTb)
echo "$out"

# Fails the script when the pass line is missing
echo "$out" | grep -q '^>>> PASS$'

//--- source/dmacBusPkg.sv
// FIFO depth, bus and byte widths, SCSI cycle state codes and the FIFO word union
package dmacBusPkg;

    localparam int FIFO_DEPTH     = 4;                      // Longwords
    localparam int WORD_W         = 32;
    localparam int BYTE_W         = 8;
    localparam int BYTES_PER_WORD = WORD_W / BYTE_W;
    localparam int PTR_W          = $clog2(FIFO_DEPTH);
    localparam int BPTR_W         = $clog2(BYTES_PER_WORD);
    localparam int WC_W           = 16;                     // Word counter width

    // SCSI port cycle states
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_STROBE  = 2'd1;
    localparam logic [1:0] ST_RECOVER = 2'd2;

    // Memory side uses the longword, SCSI side the bytes
    // Byte 3 is bits 31:24 and goes first on the port
    typedef union packed {
        logic [WORD_W-1:0]                    word;
        logic [BYTES_PER_WORD-1:0][BYTE_W-1:0] bytes;
    } fifoWordT;

endpackage

//--- source/dmacFifo.sv
// Four longword ring FIFO with a byte pointer for SCSI side packing and unpacking
module dmacFifo (
    input logic     SCLK,
    input logic     reset_i,
    fifoPortIf.fifo fp
);
    import dmacBusPkg::*;

    fifoWordT          mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic [PTR_W:0]    count;
    logic [BPTR_W-1:0] bytePtr;        // Counts 3 down to 0
    logic              lastByte;
    logic              wordIn;
    logic              wordOut;

    assign lastByte = (bytePtr == '0);
    assign wordIn   = fp.push || (fp.byteInValid && lastByte);   // Commit a packed word
    assign wordOut  = fp.pop || (fp.byteOutTake && lastByte);    // Free an unpacked word

    always_ff @(posedge SCLK) begin
        if (reset_i || fp.clear) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            bytePtr <= BPTR_W'(BYTES_PER_WORD - 1);
        end else begin
            if (wordIn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (wordOut) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (wordIn && !wordOut) begin
                count <= count + 1'b1;
            end else if (wordOut && !wordIn) begin
                count <= count - 1'b1;
            end
            if (fp.byteInValid || fp.byteOutTake) begin
                bytePtr <= bytePtr - 1'b1;                       // Wraps from 0 back to 3
            end
        end
    end

    // Bytes are staged in place in the entry at the write pointer
    always_ff @(posedge SCLK) begin
        if (fp.push) begin
            mem[wrPtr] <= fp.pushWord;
        end else if (fp.byteInValid) begin
            mem[wrPtr].bytes[bytePtr] <= fp.byteIn;
        end
    end

    assign fp.popWord = mem[rdPtr];
    assign fp.byteOut = mem[rdPtr].bytes[bytePtr];
    assign fp.full    = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign fp.empty   = (count == '0);

    noWriteWhenFull: assert property (@(posedge SCLK) disable iff (reset_i || fp.clear)
        (fp.push || fp.byteInValid) |-> !fp.full) else $error("FIFO write while full");

    noReadWhenEmpty: assert property (@(posedge SCLK) disable iff (reset_i || fp.clear)
        (fp.pop || fp.byteOutTake) |-> !fp.empty) else $error("FIFO read while empty");

endmodule

//--- source/dmacIfs.sv
// FIFO port interface and DMA control interface with their modports
interface fifoPortIf;
    import dmacBusPkg::*;

    logic              push;         // Longword from memory reads
    fifoWordT          pushWord;
    logic              pop;          // Longword for memory writes
    fifoWordT          popWord;
    logic [BYTE_W-1:0] byteIn;       // Byte from the SCSI port
    logic              byteInValid;
    logic [BYTE_W-1:0] byteOut;      // Byte to the SCSI port
    logic              byteOutTake;
    logic              full;
    logic              empty;
    logic              clear;

    modport fifo (
        input  push, pushWord, pop, byteIn, byteInValid, byteOutTake, clear,
        output popWord, byteOut, full, empty
    );
    modport memSide (output push, pushWord, pop, input popWord, full, empty);
    modport scsiSide (output byteIn, byteInValid, byteOutTake, input byteOut, full, empty);
endinterface

interface dmaCtrlIf;
    import dmacBusPkg::*;

    logic              start;        // One cycle pulses
    logic              stop;
    logic              dir;
    logic [WORD_W-1:0] startAddr;
    logic [WC_W-1:0]   wordCount;
    logic              active;
    logic              done;

    modport regs (output start, stop, dir, startAddr, wordCount, active, input done);
    modport master (input start, dir, startAddr, wordCount, active, output done);
    modport scsi (input start, dir, wordCount, active);
endinterface

//--- source/dmacRegPkg.sv
// Register map offsets, CNTR bit positions and ISTR bit positions
package dmacRegPkg;

    localparam int APB_AW = 5;      // APB byte address width

    // Register byte offsets
    localparam logic [APB_AW-1:0] REG_CNTR  = 5'h00;
    localparam logic [APB_AW-1:0] REG_ACR   = 5'h04;
    localparam logic [APB_AW-1:0] REG_WTC   = 5'h08;
    localparam logic [APB_AW-1:0] REG_STDMA = 5'h0C;
    localparam logic [APB_AW-1:0] REG_SPDMA = 5'h10;
    localparam logic [APB_AW-1:0] REG_ISTR  = 5'h14;

    // CNTR fields
    localparam int CNTR_W     = 2;
    localparam int CNTR_DIR   = 0;  // 0 SCSI to memory, 1 memory to SCSI
    localparam int CNTR_INTEN = 1;

    // ISTR fields
    localparam int ISTR_INT   = 0;
    localparam int ISTR_BUSY  = 1;
    localparam int ISTR_EMPTY = 2;
    localparam int ISTR_FULL  = 3;

endpackage

//--- source/dmacRegisters.sv
// APB register file with CNTR, ACR, WTC and ISTR, start and stop pulses, interrupt logic
module dmacRegisters (
    input  logic                          SCLK,
    input  logic                          reset_i,
    input  logic [dmacRegPkg::APB_AW-1:0] paddr_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [dmacBusPkg::WORD_W-1:0] pwdata_i,
    output logic [dmacBusPkg::WORD_W-1:0] prdata_o,
    output logic                          int_o,
    dmaCtrlIf.regs                        ctrl,
    input  logic                          fifoEmpty_i,
    input  logic                          fifoFull_i
);
    import dmacRegPkg::*;
    import dmacBusPkg::*;

    logic [CNTR_W-1:0] cntr;
    logic [WORD_W-1:0] acr;
    logic [WC_W-1:0]   wtc;
    logic              intFlag;
    logic              active;
    logic              wrEn;

    assign wrEn       = psel_i && penable_i && pwrite_i;   // Access phase write
    assign ctrl.start = wrEn && (paddr_i == REG_STDMA);
    assign ctrl.stop  = wrEn && (paddr_i == REG_SPDMA);

    always_ff @(posedge SCLK) begin
        if (reset_i) begin
            cntr <= '0;
        end else if (wrEn && (paddr_i == REG_CNTR)) begin
            cntr <= pwdata_i[CNTR_W-1:0];
        end
    end

    always_ff @(posedge SCLK) begin
        if (wrEn && (paddr_i == REG_ACR)) begin
            acr <= pwdata_i;
        end
        if (wrEn && (paddr_i == REG_WTC)) begin
            wtc <= pwdata_i[WC_W-1:0];
        end
    end

    // Transfer status and interrupt latch
    always_ff @(posedge SCLK) begin
        if (reset_i) begin
            active  <= 1'b0;
            intFlag <= 1'b0;
        end else begin
            if (ctrl.start) begin
                active <= 1'b1;
            end else if (ctrl.done || ctrl.stop) begin
                active <= 1'b0;
            end
            if (ctrl.start || ctrl.stop) begin
                intFlag <= 1'b0;                           // Acknowledged by the next command
            end else if (ctrl.done) begin
                intFlag <= 1'b1;
            end
        end
    end

    assign ctrl.active    = active;
    assign ctrl.dir       = cntr[CNTR_DIR];
    assign ctrl.startAddr = acr;
    assign ctrl.wordCount = wtc;
    assign int_o          = intFlag && cntr[CNTR_INTEN];

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            REG_CNTR: prdata_o[CNTR_W-1:0] = cntr;
            REG_ACR:  prdata_o = acr;
            REG_WTC:  prdata_o[WC_W-1:0] = wtc;
            REG_ISTR: begin
                prdata_o[ISTR_INT]   = intFlag;
                prdata_o[ISTR_BUSY]  = active;
                prdata_o[ISTR_EMPTY] = fifoEmpty_i;
                prdata_o[ISTR_FULL]  = fifoFull_i;
            end
            default: ;                                     // STDMA and SPDMA read as zero
        endcase
    end

    startStopExclusive: assert property (@(posedge SCLK) disable iff (reset_i)
        !(ctrl.start && ctrl.stop)) else $error("start and stop in one cycle");

endmodule

//--- source/dmacTop.sv
// DMA controller top level with register block, FIFO, SCSI port FSM and memory master
module dmacTop (
    input  logic                          SCLK,
    input  logic                          reset_i,
    // APB slave
    input  logic [dmacRegPkg::APB_AW-1:0] paddr_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [dmacBusPkg::WORD_W-1:0] pwdata_i,
    output logic [dmacBusPkg::WORD_W-1:0] prdata_o,
    // Memory bus
    output logic                          memReq_o,
    output logic                          memWe_o,
    output logic [dmacBusPkg::WORD_W-1:0] memAddr_o,
    output logic [dmacBusPkg::WORD_W-1:0] memWdata_o,
    input  logic [dmacBusPkg::WORD_W-1:0] memRdata_i,
    input  logic                          memAck_i,
    // SCSI peripheral port
    input  logic                          dreq_i,
    output logic                          dack_o,
    output logic                          ior_o,
    output logic                          iow_o,
    input  logic [dmacBusPkg::BYTE_W-1:0] pdIn_i,
    output logic [dmacBusPkg::BYTE_W-1:0] pdOut_o,
    output logic                          int_o
);

    fifoPortIf fifoBus ();
    dmaCtrlIf  ctrlBus ();

    assign fifoBus.clear = ctrlBus.start;   // Each transfer starts with an empty FIFO

    dmacRegisters uRegisters (
        .SCLK        (SCLK         ),
        .reset_i     (reset_i      ),
        .paddr_i     (paddr_i      ),
        .psel_i      (psel_i       ),
        .penable_i   (penable_i    ),
        .pwrite_i    (pwrite_i     ),
        .pwdata_i    (pwdata_i     ),
        .prdata_o    (prdata_o     ),
        .int_o       (int_o        ),
        .ctrl        (ctrlBus.regs ),
        .fifoEmpty_i (fifoBus.empty),
        .fifoFull_i  (fifoBus.full )
    );

    dmacFifo uFifo (.SCLK(SCLK), .reset_i(reset_i), .fp(fifoBus.fifo));

    scsiPortSm uScsiSm (
        .SCLK    (SCLK            ),
        .reset_i (reset_i         ),
        .dreq_i  (dreq_i          ),
        .pdIn_i  (pdIn_i          ),
        .pdOut_o (pdOut_o         ),
        .dack_o  (dack_o          ),
        .ior_o   (ior_o           ),
        .iow_o   (iow_o           ),
        .ctrl    (ctrlBus.scsi    ),
        .fp      (fifoBus.scsiSide)
    );

    memBusMaster uMaster (
        .SCLK       (SCLK           ),
        .reset_i    (reset_i        ),
        .memReq_o   (memReq_o       ),
        .memWe_o    (memWe_o        ),
        .memAddr_o  (memAddr_o      ),
        .memWdata_o (memWdata_o     ),
        .memRdata_i (memRdata_i     ),
        .memAck_i   (memAck_i       ),
        .ctrl       (ctrlBus.master ),
        .fp         (fifoBus.memSide)
    );

endmodule

//--- source/memBusMaster.sv
// Memory bus master with address and word counters and transfer completion
module memBusMaster (
    input  logic                          SCLK,
    input  logic                          reset_i,
    output logic                          memReq_o,
    output logic                          memWe_o,
    output logic [dmacBusPkg::WORD_W-1:0] memAddr_o,
    output logic [dmacBusPkg::WORD_W-1:0] memWdata_o,
    input  logic [dmacBusPkg::WORD_W-1:0] memRdata_i,
    input  logic                          memAck_i,
    dmaCtrlIf.master                      ctrl,
    fifoPortIf.memSide                    fp
);
    import dmacBusPkg::*;

    logic [WORD_W-1:0] addrQ;          // Address of the next longword
    logic [WC_W-1:0]   wordsLeft;
    logic              issue;
    logic              ackNow;

    assign ackNow = memReq_o && memAck_i;
    assign issue  = ctrl.active && !ctrl.start && !memReq_o && (wordsLeft != '0) &&
                    (ctrl.dir ? !fp.full : !fp.empty);

    always_ff @(posedge SCLK) begin
        if (reset_i) begin
            memReq_o  <= 1'b0;
            memWe_o   <= 1'b0;
            wordsLeft <= '0;
        end else begin
            if (ctrl.start) begin
                wordsLeft <= ctrl.wordCount;
            end else if (ackNow) begin
                wordsLeft <= wordsLeft - 1'b1;
            end
            if (memReq_o) begin
                memReq_o <= !memAck_i;                  // Held until acknowledged
            end else if (issue) begin
                memReq_o <= 1'b1;
                memWe_o  <= !ctrl.dir;
            end
        end
    end

    always_ff @(posedge SCLK) begin
        if (ctrl.start) begin
            addrQ <= ctrl.startAddr;
        end else if (ackNow) begin
            addrQ <= addrQ + WORD_W'(BYTES_PER_WORD);
        end
        if (issue) begin
            memAddr_o  <= addrQ;
            memWdata_o <= fp.popWord.word;
        end
    end

    assign fp.pop      = issue && !ctrl.dir;            // Word leaves as the write starts
    assign fp.push     = ackNow && !memWe_o && !ctrl.start;
    assign fp.pushWord = fifoWordT'(memRdata_i);

    // Writes end on the last ack, reads when the port has drained the FIFO
    assign ctrl.done = ctrl.active && !ctrl.start &&
                       (ctrl.dir ? (!memReq_o && (wordsLeft == '0) && fp.empty)
                                 : (ackNow && (wordsLeft == WC_W'(1))));

    addrStable: assert property (@(posedge SCLK) disable iff (reset_i)
        (memReq_o && !memAck_i) |=> $stable(memAddr_o) && memReq_o)
        else $error("memory request changed before ack");

endmodule

//--- source/scsiPortSm.sv
// SCSI DREQ/DACK byte transfer FSM with IOR and IOW strobes
module scsiPortSm (
    input  logic                          SCLK,
    input  logic                          reset_i,
    input  logic                          dreq_i,
    input  logic [dmacBusPkg::BYTE_W-1:0] pdIn_i,
    output logic [dmacBusPkg::BYTE_W-1:0] pdOut_o,
    output logic                          dack_o,
    output logic                          ior_o,
    output logic                          iow_o,
    dmaCtrlIf.scsi                        ctrl,
    fifoPortIf.scsiSide                   fp
);
    import dmacBusPkg::*;

    logic [1:0]      state;
    logic            phase;            // Second strobe cycle when set
    logic [WC_W+1:0] bytesLeft;
    logic            canMove;
    logic            lastStrobe;

    assign canMove    = ctrl.dir ? !fp.empty : !fp.full;
    assign lastStrobe = (state == ST_STROBE) && phase;

    always_ff @(posedge SCLK) begin
        if (reset_i) begin
            state     <= ST_IDLE;
            phase     <= 1'b0;
            bytesLeft <= '0;
        end else begin
            if (ctrl.start) begin
                bytesLeft <= {ctrl.wordCount, 2'b00};   // Four bytes per longword
            end else if (lastStrobe) begin
                bytesLeft <= bytesLeft - 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    phase <= 1'b0;
                    if (dreq_i && ctrl.active && !ctrl.start && canMove &&
                        (bytesLeft != '0)) begin
                        state <= ST_STROBE;
                    end
                end
                ST_STROBE: begin
                    phase <= !phase;
                    if (phase) begin
                        state <= ST_RECOVER;
                    end
                end
                ST_RECOVER: state <= ST_IDLE;           // Idle gap between bytes
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Head byte is captured on entry and held across the strobe
    always_ff @(posedge SCLK) begin
        if (state == ST_IDLE) begin
            pdOut_o <= fp.byteOut;
        end
    end

    assign dack_o = (state == ST_STROBE);
    assign ior_o  = dack_o && !ctrl.dir;
    assign iow_o  = dack_o && ctrl.dir;

    assign fp.byteIn      = pdIn_i;                     // Taken at the end of the second cycle
    assign fp.byteInValid = lastStrobe && !ctrl.dir;
    assign fp.byteOutTake = lastStrobe && ctrl.dir;

    noDualStrobe: assert property (@(posedge SCLK) disable iff (reset_i)
        !(ior_o && iow_o)) else $error("IOR and IOW high together");

    // Strobe lasts exactly two cycles
    strobeLength: assert property (@(posedge SCLK) disable iff (reset_i)
        $rose(dack_o) |=> dack_o ##1 !dack_o) else $error("DACK strobe length");

endmodule

//--- src.f
source/dmacRegPkg.sv
source/dmacBusPkg.sv
source/dmacIfs.sv
source/dmacRegisters.sv
source/dmacFifo.sv
source/scsiPortSm.sv
source/memBusMaster.sv
source/dmacTop.sv
test/clockGen.sv
test/dmacChecker.sv
test/dmacTb.sv

//--- test/clockGen.sv
// Testbench clock source with period 20 and a reset held for two cycles
module clockGen (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;                 // Released away from the active edge
    end

    always #10 clk_o = ~clk_o;
endmodule

//--- test/dmacChecker.sv
// Checker for memory accesses, SCSI strobes, interrupts and register reads with error counts
module dmacChecker (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        caseRun_i,      // High while a transfer of the current case runs
    input  logic        abortWatch_i,
    input  logic [7:0]  caseIdx_i,
    input  logic        caseDir_i,
    input  logic [31:0] caseAddr_i,
    input  logic [15:0] caseWords_i,
    input  logic        caseIntEn_i,
    input  logic        cmpValid_i,     // Register or pin value handed over by the testbench
    input  logic [2:0]  cmpTag_i,
    input  logic [31:0] cmpGot_i,
    input  logic [31:0] cmpExp_i,
    input  logic        memReq_i,
    input  logic        memWe_i,
    input  logic [31:0] memAddr_i,
    input  logic [31:0] memWdata_i,
    input  logic        memAck_i,
    input  logic        dreq_i,
    input  logic        dack_i,
    input  logic        ior_i,
    input  logic        iow_i,
    input  logic [7:0]  pdOut_i,
    input  logic        int_i,
    output int          errors_o,
    output int          checks_o
);
    int   words;
    int   bytesIn;
    int   bytesOut;
    int   dackLen;
    logic dackPrev;
    logic dreqPrev;
    logic intPrev;
    logic reqPrev;
    logic runPrev;

    // Byte k of a case as the peripheral supplies it
    function automatic logic [7:0] periphByte(input int k);
        return {caseIdx_i[3:0], 4'h0} + 8'(k);
    endfunction

    // Memory write data packs four peripheral bytes, first byte on top
    function automatic logic [31:0] packedWord(input int i);
        return {periphByte(4 * i), periphByte(4 * i + 1),
                periphByte(4 * i + 2), periphByte(4 * i + 3)};
    endfunction

    // Byte k on the port is taken high byte first from the memory read words
    function automatic logic [7:0] readByte(input int k);
        logic [31:0] w;
        w = (caseAddr_i + 32'(4 * (k / 4))) ^ 32'hA5A5_A5A5;
        return w[8 * (3 - k % 4) +: 8];
    endfunction

    function automatic string tagName(input logic [2:0] tag);
        case (tag)
            3'd0:    return "CNTR";
            3'd1:    return "ACR";
            3'd2:    return "WTC";
            3'd3:    return "ISTR";
            3'd4:    return "ISTR busy bit";
            default: return "int_o";
        endcase
    endfunction

    task automatic reportError(input string msg);
        errors_o = errors_o + 1;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    always @(posedge clk_i) begin
        if (reset_i) begin
            errors_o = 0;
            checks_o = 0;
            dackLen  = 0;
            {dackPrev, dreqPrev, intPrev, reqPrev, runPrev} = '0;
        end else begin
            if (!caseRun_i) begin
                if (runPrev && !abortWatch_i) begin   // Case finished normally
                    checks_o = checks_o + 1;
                    if (words != int'(caseWords_i) ||
                        (caseDir_i ? bytesOut : bytesIn) != 4 * int'(caseWords_i)) begin
                        reportError($sformatf("case %0d moved %0d words and %0d bytes",
                            caseIdx_i, words, caseDir_i ? bytesOut : bytesIn));
                    end
                end
                words    = 0;
                bytesIn  = 0;
                bytesOut = 0;
            end
            if (memReq_i && memAck_i) begin
                checks_o = checks_o + 1;
                if (!caseRun_i || words >= int'(caseWords_i)) begin
                    reportError("memory access beyond the programmed transfer");
                end else if (memWe_i == caseDir_i) begin
                    reportError("memory access in the wrong direction");
                end else if (memAddr_i != caseAddr_i + 32'(4 * words)) begin
                    reportError($sformatf("memory address 0x%08h, expected 0x%08h",
                        memAddr_i, caseAddr_i + 32'(4 * words)));
                end else if (memWe_i && memWdata_i != packedWord(words)) begin
                    reportError($sformatf("memory write data 0x%08h, expected 0x%08h",
                        memWdata_i, packedWord(words)));
                end
                words = words + 1;
            end
            if (abortWatch_i && memReq_i && !reqPrev) begin
                reportError("memory request started after the abort");
            end
            if (dack_i) begin
                dackLen = dackLen + 1;
                if (!dackPrev && !dreqPrev) reportError("DACK strobe started without DREQ");
                if (ior_i == iow_i) begin
                    reportError("DACK without exactly one of IOR and IOW");
                end else if (caseRun_i && iow_i != caseDir_i) begin
                    reportError("strobe in the wrong direction");
                end
                if (iow_i) begin
                    checks_o = checks_o + 1;
                    if (pdOut_i != readByte(bytesOut)) begin
                        reportError($sformatf("port byte %0d is 0x%02h, expected 0x%02h",
                            bytesOut, pdOut_i, readByte(bytesOut)));
                    end
                    if (dackLen == 2) bytesOut = bytesOut + 1;
                end
                if (ior_i && dackLen == 2) bytesIn = bytesIn + 1;
            end else begin
                if (dackPrev && dackLen != 2) reportError("DACK strobe not two cycles long");
                dackLen = 0;
            end
            if (caseRun_i && int_i && !intPrev) begin
                checks_o = checks_o + 1;
                if (!caseIntEn_i) reportError("interrupt raised while disabled");
                if (caseDir_i ? bytesOut != 4 * int'(caseWords_i)
                              : words != int'(caseWords_i)) begin
                    reportError("interrupt raised before the last transfer");
                end
            end
            if (cmpValid_i) begin
                checks_o = checks_o + 1;
                if (cmpGot_i != cmpExp_i) begin
                    reportError($sformatf("%s is 0x%08h, expected 0x%08h",
                        tagName(cmpTag_i), cmpGot_i, cmpExp_i));
                end
            end
            dackPrev = dack_i;
            dreqPrev = dreq_i;
            intPrev  = int_i;
            reqPrev  = memReq_i;
            runPrev  = caseRun_i;
        end
    end
endmodule

//--- test/dmacTb.sv
// DMA controller testbench with case table, APB driver, memory and peripheral models, watchdog
module dmacTb;
    import dmacRegPkg::*;

    typedef struct packed {
        logic        dir;
        logic [31:0] addr;
        logic [15:0] words;
        logic        intEn;
        logic        abort;       // Stop with SPDMA after the first memory ack
    } caseT;

    localparam int NUM_CASES = 6;
    localparam caseT CASE_TAB [NUM_CASES] = '{
        '{1'b0, 32'h0000_1000, 16'd1, 1'b1, 1'b0},
        '{1'b1, 32'h0000_2000, 16'd2, 1'b1, 1'b0},
        '{1'b0, 32'h0000_3F00, 16'd6, 1'b0, 1'b0},
        '{1'b1, 32'h0001_0040, 16'd5, 1'b0, 1'b0},
        '{1'b1, 32'h0000_4000, 16'd6, 1'b0, 1'b1},
        '{1'b0, 32'h0000_5000, 16'd4, 1'b1, 1'b0}
    };
    localparam logic [2:0] TAG_CNTR = 3'd0, TAG_ACR = 3'd1, TAG_WTC = 3'd2;
    localparam logic [2:0] TAG_ISTR = 3'd3, TAG_BUSY = 3'd4, TAG_INT = 3'd5;

    logic        sclk, resetHi;
    logic [4:0]  paddr;
    logic        psel, penable, pwrite;
    logic [31:0] pwdata, prdata;
    logic        memReq, memWe, memAck = 1'b0;
    logic [31:0] memAddr, memWdata, memRdata = '0;
    logic        dreq = 1'b0, dack, ior, iow, intPin;
    logic [7:0]  pdIn = '0, pdOut;
    logic        caseRun, abortWatch, caseDir, caseIntEn, cmpValid;
    logic [7:0]  caseIdx;
    logic [31:0] caseAddr, cmpGot, cmpExp;
    logic [15:0] caseWords;
    logic [2:0]  cmpTag;
    int          errors, checks, acksSeen = 0, byteK = 0;
    logic [31:0] rngState = 32'd72;
    logic [1:0]  ackWait;
    logic        ackArmed = 1'b0, iorPrev = 1'b0;

    clockGen clkGen (.clk_o(sclk), .reset_o(resetHi));

    dmacTop dut (
        .SCLK(sclk), .reset_i(resetHi),
        .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .pwdata_i(pwdata), .prdata_o(prdata),
        .memReq_o(memReq), .memWe_o(memWe), .memAddr_o(memAddr), .memWdata_o(memWdata),
        .memRdata_i(memRdata), .memAck_i(memAck),
        .dreq_i(dreq), .dack_o(dack), .ior_o(ior), .iow_o(iow),
        .pdIn_i(pdIn), .pdOut_o(pdOut), .int_o(intPin)
    );

    dmacChecker chk (
        .clk_i(sclk), .reset_i(resetHi), .caseRun_i(caseRun), .abortWatch_i(abortWatch),
        .caseIdx_i(caseIdx), .caseDir_i(caseDir), .caseAddr_i(caseAddr),
        .caseWords_i(caseWords), .caseIntEn_i(caseIntEn),
        .cmpValid_i(cmpValid), .cmpTag_i(cmpTag), .cmpGot_i(cmpGot), .cmpExp_i(cmpExp),
        .memReq_i(memReq), .memWe_i(memWe), .memAddr_i(memAddr), .memWdata_i(memWdata),
        .memAck_i(memAck), .dreq_i(dreq), .dack_i(dack), .ior_i(ior), .iow_i(iow),
        .pdOut_i(pdOut), .int_i(intPin), .errors_o(errors), .checks_o(checks)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge sclk);
        {paddr, pwdata, psel, penable, pwrite} = {addr, data, 3'b101};   // Setup phase
        @(negedge sclk);
        penable = 1'b1;
        @(negedge sclk);
        {psel, penable, pwrite} = 3'b000;
    endtask

    task automatic readReg(input logic [4:0] addr, output logic [31:0] data);
        @(negedge sclk);
        {paddr, psel, penable, pwrite} = {addr, 3'b100};
        @(negedge sclk);
        penable = 1'b1;
        #5 data = prdata;                // Middle of the access phase
        @(negedge sclk);
        {psel, penable} = 2'b00;
    endtask

    task automatic expectValue(input logic [2:0] tag, input logic [31:0] got,
                               input logic [31:0] exp);
        @(negedge sclk);
        {cmpTag, cmpGot, cmpExp, cmpValid} = {tag, got, exp, 1'b1};
        @(negedge sclk);
        cmpValid = 1'b0;
    endtask

    // Memory with random ack delay and peripheral with random DREQ
    always @(negedge sclk) begin
        if (resetHi) begin
            {memAck, ackArmed, dreq} = 3'b000;
        end else begin
            if (memAck) begin
                {memAck, ackArmed} = 2'b00;
            end else if (memReq) begin
                if (!ackArmed) begin
                    rngState = xorshift32(rngState);
                    ackWait  = rngState[1:0];             // 0 to 3 cycles
                    ackArmed = 1'b1;
                end
                if (ackWait == 2'd0) begin
                    memRdata = memAddr ^ 32'hA5A5_A5A5;
                    memAck   = 1'b1;
                    acksSeen = acksSeen + 1;
                end else begin
                    ackWait = ackWait - 2'd1;
                end
            end
            rngState = xorshift32(rngState);
            dreq = (rngState[3:2] != 2'b00);
            if (!caseRun) byteK = 0;
            else if (iorPrev && !ior) byteK = byteK + 1;  // Byte taken at the strobe end
            iorPrev = ior;
            pdIn = {caseIdx[3:0], 4'h0} + 8'(byteK);
        end
    end

    initial begin
        caseT        tc;
        logic [31:0] rd, cntrVal, istrExp;
        int          acksBefore;
        {paddr, pwdata, psel, penable, pwrite} = '0;
        {caseRun, abortWatch, caseDir, caseIntEn, cmpValid} = '0;
        {caseIdx, caseAddr, caseWords, cmpTag, cmpGot, cmpExp} = '0;
        wait (!resetHi);
        for (int i = 0; i < NUM_CASES; i++) begin
            tc = CASE_TAB[i];
            {caseIdx, caseDir, caseAddr, caseWords, caseIntEn} =
                {8'(i), tc.dir, tc.addr, tc.words, tc.intEn};
            cntrVal = '0;
            cntrVal[CNTR_DIR]   = tc.dir;
            cntrVal[CNTR_INTEN] = tc.intEn;
            writeReg(REG_ACR, tc.addr);
            writeReg(REG_WTC, {16'h0, tc.words});
            writeReg(REG_CNTR, cntrVal);
            readReg(REG_ACR, rd);
            expectValue(TAG_ACR, rd, tc.addr);
            readReg(REG_WTC, rd);
            expectValue(TAG_WTC, rd, {16'h0, tc.words});
            readReg(REG_CNTR, rd);
            expectValue(TAG_CNTR, rd, cntrVal);
            acksBefore = acksSeen;
            writeReg(REG_STDMA, '0);
            caseRun = 1'b1;
            expectValue(TAG_INT, {31'h0, intPin}, '0);   // Old interrupt is gone
            if (tc.abort) begin
                wait (acksSeen != acksBefore);
                writeReg(REG_SPDMA, '0);
                @(negedge sclk);
                abortWatch = 1'b1;
                readReg(REG_ISTR, rd);
                expectValue(TAG_BUSY, {31'h0, rd[ISTR_BUSY]}, '0);
                while (memReq) @(negedge sclk);
                repeat (10) @(negedge sclk);              // Window with no new requests
                caseRun = 1'b0;
                @(negedge sclk);
                abortWatch = 1'b0;
            end else begin
                if (tc.intEn) begin
                    while (!intPin) @(negedge sclk);
                end else begin
                    do readReg(REG_ISTR, rd); while (rd[ISTR_BUSY]);
                end
                istrExp = '0;
                istrExp[ISTR_INT]   = 1'b1;
                istrExp[ISTR_EMPTY] = 1'b1;
                readReg(REG_ISTR, rd);
                expectValue(TAG_ISTR, rd, istrExp);
                caseRun = 1'b0;
                repeat (2) @(negedge sclk);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog sized by the words in the case table
    initial begin
        int totalWords;
        totalWords = 0;
        for (int i = 0; i < NUM_CASES; i++) totalWords += int'(CASE_TAB[i].words);
        repeat (totalWords * 200 + 1000) @(posedge sclk);
        $display("Watchdog expired before all cases finished");
        $display(">>> FAIL");
        $finish;
    end
endmodule
